/* compile.f */
source/isa_pkg.sv
source/core_pkg.sv
source/fetch.sv
source/id.sv
source/regfile.sv
source/issue.sv
source/ex.sv
source/commit.sv
source/riscv.sv
verification/tb_memory.sv
verification/riscv_tb.sv

/* Bender.yml */
package:
  name: riscv

sources:
  - files:
      - source/isa_pkg.sv
      - source/core_pkg.sv
      - source/fetch.sv
      - source/id.sv
      - source/regfile.sv
      - source/issue.sv
      - source/ex.sv
      - source/commit.sv
      - source/riscv.sv
  - target: test
    files:
      - verification/tb_memory.sv
      - verification/riscv_tb.sv

/* verification/riscv_tb.sv */
`timescale 1ns/1ps

module riscv_tb;
  import isa_pkg::*;

  localparam int          CLK_PERIOD   = 40;
  localparam int          RESET_CYCLES = 5;
  localparam int          NUM_WORDS    = 44;
  localparam int          NUM_DATA     = 3;
  localparam int          NUM_STORES   = 20;
  localparam int          NUM_LOADS    = 5;
  localparam logic [31:0] DATA_BASE    = 32'h0000_1000;
  localparam logic [31:0] NOP          = 32'h0000_0013;
  localparam logic [6:0]  IMM_OPC      = 7'b0010011;
  localparam logic [6:0]  LOAD_OPC     = 7'b0000011;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    ldst_mode_t  mode;
  } store_t;

  typedef struct packed {
    logic [31:0] addr;
    ldst_mode_t  mode;
  } load_t;

  logic        clk;
  logic        arst_n;
  logic [31:0] rd[4];
  logic [31:0] ra[4];
  ldst_mode_t  rm[4];
  logic        we;
  logic [31:0] wa;
  logic [31:0] wd;
  ldst_mode_t  wm;

  logic [31:0] program_words[NUM_WORDS];
  logic [31:0] data_words[NUM_DATA];
  store_t      expected[NUM_STORES];
  store_t      exp_store;
  load_t       loads[NUM_LOADS];
  load_t       exp_load;
  int          store_idx = 0;
  int          load_idx = 0;
  int          checks = 0;
  int          errors = 0;

  riscv dut (.clk, .arst_n, .rd, .we, .ra, .wa, .wd, .rm, .wm);

  tb_memory mem (.clk, .ra, .rd, .we, .wa, .wd, .wm);

  function automatic logic [31:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                         input int dst, input int src1, input int src2);
    return {f7, 5'(src2), 5'(src1), f3, 5'(dst), 7'b0110011};
  endfunction

  function automatic logic [31:0] i_word(input logic [6:0] opc, input logic [2:0] f3,
                                         input int dst, input int src1, input int imm);
    return {12'(imm), 5'(src1), f3, 5'(dst), opc};
  endfunction

  function automatic logic [31:0] s_word(input logic [2:0] f3, input int src2,
                                         input int src1, input int imm);
    logic [11:0] im;
    im = 12'(imm);
    return {im[11:5], 5'(src2), 5'(src1), f3, im[4:0], 7'b0100011};
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expect_val);
    checks++;
    if (actual !== expect_val) begin
      errors++;
      $display("Mismatch %s: got %h, expected %h", name, actual, expect_val);
    end
  endtask

  task automatic finish_run();
    $display("Stores seen: %0d of %0d, checks: %0d, errors: %0d",
             store_idx, NUM_STORES, checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    arst_n = 1'b0;
    // One line per fetched pair, x10 ends up as the data base
    program_words = '{
      i_word(IMM_OPC, 3'd0, 1, 0, 100),   i_word(IMM_OPC, 3'd0, 2, 0, -7),
      r_word(7'h00, 3'd0, 3, 1, 2),       r_word(7'h20, 3'd0, 4, 1, 2),
      r_word(7'h00, 3'd7, 5, 1, 2),       r_word(7'h00, 3'd6, 6, 1, 2),
      r_word(7'h00, 3'd4, 7, 1, 2),       i_word(IMM_OPC, 3'd0, 10, 0, 1024),
      r_word(7'h00, 3'd0, 10, 10, 10),    r_word(7'h00, 3'd0, 10, 10, 10),
      s_word(3'd2, 3, 10, 'h100),         i_word(IMM_OPC, 3'd0, 8, 0, 5),
      s_word(3'd2, 4, 10, 'h104),         s_word(3'd2, 5, 10, 'h108),
      s_word(3'd2, 6, 10, 'h10c),         s_word(3'd2, 7, 10, 'h110),
      i_word(IMM_OPC, 3'd0, 9, 8, 3),     r_word(7'h00, 3'd0, 11, 9, 9),
      s_word(3'd2, 11, 10, 'h114),        s_word(3'd2, 2, 10, 'h118),
      i_word(LOAD_OPC, 3'd0, 12, 10, 3),  i_word(LOAD_OPC, 3'd4, 13, 10, 0),
      i_word(LOAD_OPC, 3'd1, 14, 10, 4),  i_word(LOAD_OPC, 3'd5, 15, 10, 2),
      i_word(LOAD_OPC, 3'd2, 16, 10, 4),  s_word(3'd2, 12, 10, 'h11c),
      s_word(3'd2, 13, 10, 'h120),        s_word(3'd2, 14, 10, 'h124),
      s_word(3'd2, 15, 10, 'h128),        s_word(3'd2, 16, 10, 'h12c),
      s_word(3'd0, 7, 10, 'h131),         s_word(3'd1, 2, 10, 'h136),
      s_word(3'd2, 3, 10, 8),             i_word(LOAD_OPC, 3'd2, 17, 10, 8),
      s_word(3'd0, 1, 10, 9),             i_word(LOAD_OPC, 3'd4, 18, 10, 9),
      s_word(3'd2, 17, 10, 'h138),        s_word(3'd2, 18, 10, 'h13c),
      i_word(LOAD_OPC, 3'd2, 19, 10, 8),  r_word(7'h00, 3'd0, 20, 19, 1),
      s_word(3'd2, 20, 10, 'h140),        s_word(3'd2, 19, 10, 'h144),
      NOP,                                NOP
    };
    data_words = '{32'h8765_43a1, 32'h1234_f0e2, 32'h5555_aaaa};
    // x1 = 100, x2 = -7
    expected = '{
      {32'h0000_1100, 32'h0000_005d, WORD},
      {32'h0000_1104, 32'h0000_006b, WORD},
      {32'h0000_1108, 32'h0000_0060, WORD},
      {32'h0000_110c, 32'hffff_fffd, WORD},
      {32'h0000_1110, 32'hffff_ff9d, WORD},
      {32'h0000_1114, 32'h0000_0010, WORD},
      {32'h0000_1118, 32'hffff_fff9, WORD},
      {32'h0000_111c, 32'hffff_ff87, WORD},
      {32'h0000_1120, 32'h0000_00a1, WORD},
      {32'h0000_1124, 32'hffff_f0e2, WORD},
      {32'h0000_1128, 32'h0000_8765, WORD},
      {32'h0000_112c, 32'h1234_f0e2, WORD},
      {32'h0000_1131, 32'hffff_ff9d, BYTE},
      {32'h0000_1136, 32'hffff_fff9, HALF},
      {32'h0000_1008, 32'h0000_005d, WORD},
      {32'h0000_1009, 32'h0000_0064, BYTE},
      {32'h0000_1138, 32'h0000_005d, WORD},
      {32'h0000_113c, 32'h0000_0064, WORD},
      {32'h0000_1140, 32'h0000_64c1, WORD},
      {32'h0000_1144, 32'h0000_645d, WORD}
    };
    // Aligned word and mode of each load from the first two data words
    loads = '{
      {32'h0000_1000, BYTE},
      {32'h0000_1000, BYTE_U},
      {32'h0000_1004, HALF},
      {32'h0000_1000, HALF_U},
      {32'h0000_1004, WORD}
    };
    mem.clear_all();
    for (int i = 0; i < NUM_WORDS; i++) mem.write_word(32'(4 * i), program_words[i]);
    for (int i = 0; i < NUM_DATA; i++) mem.write_word(DATA_BASE + 32'(4 * i), data_words[i]);
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;
    wait (store_idx >= NUM_STORES);
    // A few idle cycles to catch stray strobes
    repeat (10) @(posedge clk);
    check_value("load accesses", load_idx, NUM_LOADS);
    finish_run();
  end

  // Store monitor
  initial begin
    forever begin
      @(negedge clk);
      if (we === 1'b1) begin
        if (store_idx < NUM_STORES) begin
          exp_store = expected[store_idx];
          check_value($sformatf("wa (store %0d)", store_idx), wa, exp_store.addr);
          check_value($sformatf("wd (store %0d)", store_idx), wd, exp_store.data);
          check_value($sformatf("wm (store %0d)", store_idx), {29'd0, wm},
                      {29'd0, exp_store.mode});
        end else begin
          errors++;
          $display("Unexpected extra store to address %h", wa);
        end
        store_idx++;
      end
    end
  end

  // Fetch ports read words, load ports carry the load's own mode
  initial begin
    forever begin
      @(negedge clk);
      if (arst_n === 1'b1) begin
        for (int p = 0; p < 2; p++) begin
          check_value($sformatf("rm[%0d]", p), {29'd0, rm[p]}, {29'd0, WORD});
        end
        for (int p = 2; p < 4; p++) begin
          if (ra[p] >= DATA_BASE && ra[p] < DATA_BASE + 32'd8) begin
            if (load_idx < NUM_LOADS) begin
              exp_load = loads[load_idx];
              check_value($sformatf("ra[%0d] (load %0d)", p, load_idx), ra[p],
                          exp_load.addr);
              check_value($sformatf("rm[%0d] (load %0d)", p, load_idx), {29'd0, rm[p]},
                          {29'd0, exp_load.mode});
            end
            load_idx++;
          end
        end
      end
    end
  end

  initial begin
    repeat (RESET_CYCLES + 4 * NUM_WORDS + 50) @(posedge clk);
    errors++;
    $display("Timeout: only %0d of %0d expected stores appeared", store_idx, NUM_STORES);
    finish_run();
  end

endmodule

/* verification/tb_memory.sv */
`timescale 1ns/1ps

module tb_memory (
  input  logic                clk,
  input  logic [31:0]         ra[4],
  output logic [31:0]         rd[4],
  input  logic                we,
  input  logic [31:0]         wa,
  input  logic [31:0]         wd,
  input  isa_pkg::ldst_mode_t wm
);
  import isa_pkg::*;

  localparam int ADDR_BITS = 13;

  logic [7:0]           bytes[2 ** ADDR_BITS];
  logic [ADDR_BITS-1:0] waddr;

  // Reads return the whole aligned word
  for (genvar i = 0; i < 4; i++) begin : g_read
    logic [ADDR_BITS-1:0] base;
    assign base  = {ra[i][ADDR_BITS-1:2], 2'b00};
    assign rd[i] = {bytes[base + 3], bytes[base + 2], bytes[base + 1], bytes[base]};
  end

  assign waddr = wa[ADDR_BITS-1:0];

  always @(posedge clk) begin
    if (we) begin
      bytes[waddr] <= wd[7:0];
      if (wm == HALF || wm == WORD) bytes[waddr + 1] <= wd[15:8];
      if (wm == WORD) begin
        bytes[waddr + 2] <= wd[23:16];
        bytes[waddr + 3] <= wd[31:24];
      end
    end
  end

  // All-zero words decode as bubbles
  task automatic clear_all();
    for (int i = 0; i < 2 ** ADDR_BITS; i++) bytes[i] <= 8'h00;
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    for (int b = 0; b < 4; b++) bytes[addr[ADDR_BITS-1:0] + b] <= data[8 * b +: 8];
  endtask

endmodule

/* source/riscv.sv */
`timescale 1ns/1ps

module riscv (
  input  logic                clk,
  input  logic                arst_n,

  // Memory bus, ports 0/1 fetch and 2/3 load
  input  logic [31:0]         rd[4],
  output logic                we,
  output logic [31:0]         ra[4],
  output logic [31:0]         wa,
  output logic [31:0]         wd,
  output isa_pkg::ldst_mode_t rm[4],
  output isa_pkg::ldst_mode_t wm
);
  import isa_pkg::*;
  import core_pkg::*;

  logic [31:0] pc[ISSUE_WIDTH], instr[ISSUE_WIDTH];
  logic        take, store_in_commit;
  logic [4:0]  reg_addr[2 * ISSUE_WIDTH];
  logic [31:0] reg_data[2 * ISSUE_WIDTH];
  logic        reg_we[ISSUE_WIDTH];
  logic [4:0]  reg_wa[ISSUE_WIDTH];
  logic [31:0] reg_wd[ISSUE_WIDTH];
  ex_content_t ex_contents[ISSUE_WIDTH];
  ex_result_t  ex_results[ISSUE_WIDTH];

  fetch u_fetch (.clk, .arst_n, .take, .pc);

  for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_fetch_bus
    assign ra[i]    = pc[i];
    assign rm[i]    = WORD;
    assign instr[i] = rd[i];
  end

  regfile u_regfile (
    .clk, .arst_n,
    .ra(reg_addr), .rd(reg_data),
    .wa(reg_wa), .we(reg_we), .wd(reg_wd)
  );

  issue u_issue (
    .clk, .arst_n, .instr, .pc, .store_in_commit, .take,
    .reg_addr, .reg_data, .ex_contents
  );

  for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_ex
    ex u_ex (
      .ex_content(ex_contents[i]),
      .load_addr(ra[ISSUE_WIDTH + i]),
      .load_mode(rm[ISSUE_WIDTH + i]),
      .load_data(rd[ISSUE_WIDTH + i]),
      .result(ex_results[i])
    );
  end

  commit u_commit (
    .clk, .arst_n, .results(ex_results),
    .reg_we, .reg_wa, .reg_wd, .store_in_commit,
    .we, .wa, .wd, .wm
  );

endmodule

/* source/commit.sv */
`timescale 1ns/1ps

module commit (
  input  logic                 clk,
  input  logic                 arst_n,
  input  core_pkg::ex_result_t results[core_pkg::ISSUE_WIDTH],
  output logic                 reg_we[core_pkg::ISSUE_WIDTH],
  output logic [4:0]           reg_wa[core_pkg::ISSUE_WIDTH],
  output logic [31:0]          reg_wd[core_pkg::ISSUE_WIDTH],
  output logic                 store_in_commit,
  output logic                 we,
  output logic [31:0]          wa,
  output logic [31:0]          wd,
  output isa_pkg::ldst_mode_t  wm
);
  import core_pkg::*;

  logic       valid_q[ISSUE_WIDTH];
  ex_result_t res_q[ISSUE_WIDTH];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < ISSUE_WIDTH; i++) valid_q[i] <= 1'b0;
    end else begin
      for (int i = 0; i < ISSUE_WIDTH; i++) valid_q[i] <= results[i].is_valid;
    end
  end

  always_ff @(posedge clk) begin
    res_q <= results;
  end

  // Issue never lets two stores reach commit together
  always_comb begin
    we = 1'b0;
    wa = res_q[0].store_addr;
    wd = res_q[0].store_data;
    wm = res_q[0].store_mode;
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      reg_we[i] = valid_q[i] && res_q[i].writes_rd;
      reg_wa[i] = res_q[i].rd;
      reg_wd[i] = res_q[i].value;
      if (valid_q[i] && res_q[i].is_store) begin
        we = 1'b1;
        wa = res_q[i].store_addr;
        wd = res_q[i].store_data;
        wm = res_q[i].store_mode;
      end
    end
  end

  assign store_in_commit = we;

endmodule

/* source/ex.sv */
`timescale 1ns/1ps

module ex (
  input  core_pkg::ex_content_t ex_content,
  output logic [31:0]           load_addr,
  output isa_pkg::ldst_mode_t   load_mode,
  input  logic [31:0]           load_data,
  output core_pkg::ex_result_t  result
);
  import isa_pkg::*;

  decode_result_t d;
  logic [31:0]    a, b, addr, shifted, load_value, alu_value;

  assign d         = ex_content.decoded;
  assign a         = ex_content.rs1_val;
  assign b         = ex_content.rs2_val;
  assign addr      = a + d.imm;
  assign load_addr = {addr[31:2], 2'b00};
  assign load_mode = d.mode;

  // Byte lane selection within the aligned word
  assign shifted = load_data >> {addr[1:0], 3'b000};

  always_comb begin
    case (d.mode)
      BYTE:    load_value = {{24{shifted[7]}}, shifted[7:0]};
      BYTE_U:  load_value = {24'd0, shifted[7:0]};
      HALF:    load_value = {{16{shifted[15]}}, shifted[15:0]};
      HALF_U:  load_value = {16'd0, shifted[15:0]};
      default: load_value = load_data;
    endcase
  end

  always_comb begin
    case (d.op)
      OP_ADD:  alu_value = a + b;
      OP_SUB:  alu_value = a - b;
      OP_AND:  alu_value = a & b;
      OP_OR:   alu_value = a | b;
      OP_XOR:  alu_value = a ^ b;
      OP_ADDI: alu_value = addr;
      default: alu_value = d.is_load ? load_value : '0;
    endcase
  end

  always_comb begin
    result.is_valid   = d.is_valid;
    result.writes_rd  = d.is_valid && d.writes_rd;
    result.rd         = d.rd;
    result.value      = alu_value;
    result.is_store   = d.is_valid && d.is_store;
    result.store_addr = addr;
    result.store_data = b;
    result.store_mode = d.mode;
  end

endmodule

/* source/issue.sv */
`timescale 1ns/1ps

module issue (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic [31:0]          instr[core_pkg::ISSUE_WIDTH],
  input  logic [31:0]          pc[core_pkg::ISSUE_WIDTH],
  input  logic                 store_in_commit,
  output logic                 take,
  output logic [4:0]           reg_addr[2 * core_pkg::ISSUE_WIDTH],
  input  logic [31:0]          reg_data[2 * core_pkg::ISSUE_WIDTH],
  output core_pkg::ex_content_t ex_contents[core_pkg::ISSUE_WIDTH]
);
  import isa_pkg::*;
  import core_pkg::*;

  logic           pair_valid[ISSUE_WIDTH];
  logic [31:0]    pair_instr[ISSUE_WIDTH];
  decode_result_t decoded[ISSUE_WIDTH];
  issue_state_t   state, state_next, return_state;
  logic           issue_sel[ISSUE_WIDTH];
  logic           split, stall;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < ISSUE_WIDTH; i++) pair_valid[i] <= 1'b0;
    end else if (take) begin
      for (int i = 0; i < ISSUE_WIDTH; i++) pair_valid[i] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      pair_instr <= instr;
    end
  end

  for (genvar i = 0; i < ISSUE_WIDTH; i++) begin : g_id
    id u_id (
      .is_valid(pair_valid[i]),
      .instr(pair_instr[i]),
      .decoded(decoded[i])
    );
    assign reg_addr[2 * i]     = decoded[i].rs1;
    assign reg_addr[2 * i + 1] = decoded[i].rs2;
  end

  // Register dependency, store then load, or two stores on one write port
  assign split = decoded[1].is_valid &&
                 ((decoded[0].writes_rd && (decoded[1].rs1 == decoded[0].rd ||
                                            decoded[1].rs2 == decoded[0].rd)) ||
                  (decoded[0].is_store && (decoded[1].is_store || decoded[1].is_load)));

  always_comb begin
    issue_sel[0] = (state == ISSUE_PAIR);
    issue_sel[1] = (state == ISSUE_PAIR && !split) || (state == ISSUE_SECOND);
    stall = 1'b0;
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      if (issue_sel[i] && decoded[i].is_load && store_in_commit) stall = 1'b1;
    end

    take       = 1'b0;
    state_next = state;
    if (stall) begin
      state_next = WAIT_STORE;
    end else begin
      case (state)
        ISSUE_PAIR: begin
          take = !split;
          if (split) state_next = ISSUE_SECOND;
        end
        ISSUE_SECOND: begin
          take       = 1'b1;
          state_next = ISSUE_PAIR;
        end
        default: state_next = return_state;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state        <= ISSUE_PAIR;
      return_state <= ISSUE_PAIR;
    end else begin
      state <= state_next;
      if (stall) return_state <= state;
    end
  end

  always_comb begin
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      ex_contents[i] = '0;
      if (issue_sel[i] && !stall) begin
        ex_contents[i].decoded = decoded[i];
        ex_contents[i].rs1_val = reg_data[2 * i];
        ex_contents[i].rs2_val = reg_data[2 * i + 1];
      end
    end
  end

endmodule

/* source/regfile.sv */
`timescale 1ns/1ps

module regfile (
  input  logic        clk,
  input  logic        arst_n,
  input  logic [4:0]  ra[4],
  output logic [31:0] rd[4],
  input  logic [4:0]  wa[2],
  input  logic        we[2],
  input  logic [31:0] wd[2]
);

  logic [31:0] regs[32];

  // Port 1 is written last so it wins on equal addresses
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) regs[i] <= '0;
    end else begin
      for (int p = 0; p < 2; p++) begin
        if (we[p] && wa[p] != 5'd0) regs[wa[p]] <= wd[p];
      end
    end
  end

  // Write-through bypass
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      if (ra[i] == 5'd0) rd[i] = '0;
      else if (we[1] && wa[1] == ra[i]) rd[i] = wd[1];
      else if (we[0] && wa[0] == ra[i]) rd[i] = wd[0];
      else rd[i] = regs[ra[i]];
    end
  end

endmodule

/* source/id.sv */
`timescale 1ns/1ps

module id (
  input  logic                    is_valid,
  input  logic [31:0]             instr,
  output isa_pkg::decode_result_t decoded
);
  import isa_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];

  always_comb begin
    decoded      = '0;
    decoded.op   = OP_NOP;
    decoded.mode = WORD;
    if (is_valid) begin
      case (opcode)
        OPC_REG: begin
          case ({instr[31:25], funct3})
            10'b0000000_000: decoded.op = OP_ADD;
            10'b0100000_000: decoded.op = OP_SUB;
            10'b0000000_111: decoded.op = OP_AND;
            10'b0000000_110: decoded.op = OP_OR;
            10'b0000000_100: decoded.op = OP_XOR;
            default:         decoded.op = OP_NOP;
          endcase
        end
        OPC_IMM: if (funct3 == 3'b000) decoded.op = OP_ADDI;
        OPC_LOAD: begin
          case (funct3)
            3'b000:  decoded.op = OP_LB;
            3'b001:  decoded.op = OP_LH;
            3'b010:  decoded.op = OP_LW;
            3'b100:  decoded.op = OP_LBU;
            3'b101:  decoded.op = OP_LHU;
            default: decoded.op = OP_NOP;
          endcase
        end
        OPC_STORE: begin
          case (funct3)
            3'b000:  decoded.op = OP_SB;
            3'b001:  decoded.op = OP_SH;
            3'b010:  decoded.op = OP_SW;
            default: decoded.op = OP_NOP;
          endcase
        end
        default: decoded.op = OP_NOP;
      endcase
    end

    // Unused source fields stay zero so hazard checks see no false match
    if (decoded.op != OP_NOP) begin
      decoded.is_valid  = 1'b1;
      decoded.is_load   = (opcode == OPC_LOAD);
      decoded.is_store  = (opcode == OPC_STORE);
      decoded.rs1       = instr[19:15];
      decoded.writes_rd = !decoded.is_store && (instr[11:7] != 5'd0);
      if (opcode == OPC_REG || decoded.is_store) decoded.rs2 = instr[24:20];
      if (!decoded.is_store) decoded.rd = instr[11:7];
      if (decoded.is_store) begin
        decoded.imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
      end else if (opcode != OPC_REG) begin
        decoded.imm = {{20{instr[31]}}, instr[31:20]};
      end
      if (decoded.is_load || decoded.is_store) begin
        case (funct3)
          3'b000:  decoded.mode = BYTE;
          3'b001:  decoded.mode = HALF;
          3'b100:  decoded.mode = BYTE_U;
          3'b101:  decoded.mode = HALF_U;
          default: decoded.mode = WORD;
        endcase
      end
    end
  end

endmodule

/* source/fetch.sv */
`timescale 1ns/1ps

module fetch (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        take,
  output logic [31:0] pc[core_pkg::ISSUE_WIDTH]
);
  import core_pkg::*;

  logic [31:0] pc_q;

  // Advance by one whole pair once it has issued
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q <= RESET_PC;
    end else if (take) begin
      pc_q <= pc_q + 32'(4 * ISSUE_WIDTH);
    end
  end

  always_comb begin
    for (int i = 0; i < ISSUE_WIDTH; i++) begin
      pc[i] = pc_q + 32'(4 * i);
    end
  end

endmodule

/* source/core_pkg.sv */
package core_pkg;

  localparam int          ISSUE_WIDTH = 2;
  localparam logic [31:0] RESET_PC    = 32'h0000_0000;

  typedef enum logic [1:0] {ISSUE_PAIR, ISSUE_SECOND, WAIT_STORE} issue_state_t;

  typedef struct packed {
    isa_pkg::decode_result_t decoded;
    logic [31:0]             rs1_val;
    logic [31:0]             rs2_val;
  } ex_content_t;

  typedef struct packed {
    logic                is_valid;
    logic                writes_rd;
    logic [4:0]          rd;
    logic [31:0]         value;
    logic                is_store;
    logic [31:0]         store_addr;
    logic [31:0]         store_data;
    isa_pkg::ldst_mode_t store_mode;
  } ex_result_t;

endpackage

/* source/isa_pkg.sv */
package isa_pkg;

  // Major opcodes of the supported formats
  localparam logic [6:0] OPC_REG   = 7'b0110011;
  localparam logic [6:0] OPC_IMM   = 7'b0010011;
  localparam logic [6:0] OPC_LOAD  = 7'b0000011;
  localparam logic [6:0] OPC_STORE = 7'b0100011;

  // OP_NOP first so that an all-zero slot is a bubble
  typedef enum logic [3:0] {
    OP_NOP,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_OR,
    OP_XOR,
    OP_ADDI,
    OP_LB,
    OP_LH,
    OP_LW,
    OP_LBU,
    OP_LHU,
    OP_SB,
    OP_SH,
    OP_SW
  } opcode_t;

  typedef enum logic [2:0] {BYTE, HALF, WORD, BYTE_U, HALF_U} ldst_mode_t;

  typedef struct packed {
    logic        is_valid;
    opcode_t     op;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [31:0] imm;
    logic        writes_rd;
    logic        is_load;
    logic        is_store;
    ldst_mode_t  mode;
  } decode_result_t;

endpackage
